//--- hw/cpu_decode.sv
// CPU bus decoder: block selects from the address map and one-clock read data return
`timescale 1ns/1ps
`include "vid_consts.svh"

module cpu_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_cs,
    input  logic                cpu_rnw,
    input  vid_pkg::cpu_addr_t  cpu_addr,
    output logic                scr_cs,
    output logic                txt_cs,
    output logic                pal_cs,
    input  vid_pkg::cpu_data_t  scr_rd,
    input  vid_pkg::cpu_data_t  txt_rd,
    input  vid_pkg::cpu_data_t  pal_rd,
    output vid_pkg::cpu_data_t  cpu_din
);
    import vid_pkg::*;

    localparam cpu_addr_t SCR_CODE = `ADDR_SCR_CODE;
    localparam cpu_addr_t SCR_ATTR = `ADDR_SCR_ATTR;
    localparam cpu_addr_t TXT_CODE = `ADDR_TXT_CODE;
    localparam cpu_addr_t PAL_BASE = `ADDR_PAL;

    logic       scr_hit;
    logic       txt_hit;
    logic       pal_hit;
    logic [2:0] rd_sel;    // {pal, txt, scr} of the last read strobe

    always_comb begin
        scr_hit = cpu_addr[11:10] == SCR_CODE[11:10] ||
                  cpu_addr[11:10] == SCR_ATTR[11:10] ||
                  cpu_addr == `ADDR_SCROLL;
        txt_hit = cpu_addr[11:10] == TXT_CODE[11:10] || cpu_addr == `ADDR_TXT_COLOR;
        pal_hit = cpu_addr[11:8] == PAL_BASE[11:8];    // Whole 256 byte page
    end

    assign scr_cs = cpu_cs & scr_hit;
    assign txt_cs = cpu_cs & txt_hit;
    assign pal_cs = cpu_cs & pal_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_sel <= '0;
        end else begin
            rd_sel <= (cpu_cs && cpu_rnw) ? {pal_hit, txt_hit, scr_hit} : 3'b000;
        end
    end

    // Blocks answer one clk after the strobe, same as rd_sel
    always_comb begin
        case (rd_sel)
            3'b001:  cpu_din = scr_rd;
            3'b010:  cpu_din = txt_rd;
            3'b100:  cpu_din = pal_rd;
            default: cpu_din = '0;    // Unmapped
        endcase
    end

endmodule

//--- hw/dual_port_ram.sv
// Dual port RAM: CPU write/read port plus a video read port, both synchronous
`timescale 1ns/1ps

module dual_port_ram #(
    parameter int AW = 10,
    parameter int DW = 8
) (
    input  logic          clk,
    // CPU side
    input  logic          we,
    input  logic [AW-1:0] wr_addr,    // Also the CPU read address
    input  logic [DW-1:0] wr_data,
    output logic [DW-1:0] cpu_q,
    // Video side
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_q
);

    logic [DW-1:0] mem [0:(1 << AW) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        cpu_q <= mem[wr_addr];    // Old data on a write cycle
        rd_q  <= mem[rd_addr];
    end

endmodule

//--- hw/layer_mixer.sv
// Layer mixer: priority select between text and scroll pixels, then palette RAM lookup
`timescale 1ns/1ps

module layer_mixer (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  vid_pkg::pix_idx_t  scr_idx,
    input  logic               scr_prio,
    input  vid_pkg::pix_idx_t  txt_idx,
    input  logic               txt_opaque,
    input  logic               pal_cs,
    input  logic               cpu_rnw,
    input  vid_pkg::cpu_addr_t cpu_addr,
    input  vid_pkg::cpu_data_t cpu_dout,
    output vid_pkg::cpu_data_t pal_rd,
    output vid_pkg::rgb_t      rgb
);
    import vid_pkg::*;

    logic     pal_we;
    logic     scr_wins;    // Priority tile with a solid pixel
    pix_idx_t mix_idx;
    pix_idx_t mix_q;
    rgb_t     pal_q;

    assign pal_we   = pal_cs & ~cpu_rnw;
    assign scr_wins = scr_prio && (scr_idx[3:0] != 4'd0);
    assign mix_idx  = (txt_opaque && !scr_wins) ? txt_idx : scr_idx;

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            mix_q <= mix_idx;
        end
    end

    // 256 entries of RGB332
    dual_port_ram #(.AW(8), .DW(8)) pal_ram (
        .clk     (clk),
        .we      (pal_we),
        .wr_addr (cpu_addr[7:0]),
        .wr_data (cpu_dout),
        .cpu_q   (pal_rd),
        .rd_addr (mix_q),
        .rd_q    (pal_q)
    );

    // RAM answers between enables, so one step covers the lookup
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb <= pal_q;
        end
    end

endmodule

//--- hw/scroll_layer.sv
// Scroll layer: vertically scrolled 4bpp tilemap with fixed score columns and tile fetch
`timescale 1ns/1ps
`include "vid_consts.svh"

module scroll_layer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  vid_pkg::hcount_t        hdump,
    input  vid_pkg::vcount_t        vdump,
    input  logic                    scr_cs,
    input  logic                    cpu_rnw,
    input  vid_pkg::cpu_addr_t      cpu_addr,
    input  vid_pkg::cpu_data_t      cpu_dout,
    output vid_pkg::cpu_data_t      scr_rd,
    output vid_pkg::scr_rom_addr_t  scr_rom_addr,
    input  vid_pkg::tile_row_t      scr_rom_data,
    output vid_pkg::pix_idx_t       scr_idx,
    output logic                    scr_prio
);
    import vid_pkg::*;

    cpu_data_t  scroll;          // Written at 0xC00
    cpu_data_t  code;
    cpu_data_t  attr;
    cpu_data_t  code_q;
    cpu_data_t  attr_q;
    logic [1:0] cpu_sel;         // Address bits 11:10 of the last cycle
    logic       code_we;
    logic       attr_we;
    hcount_t    h_next;
    logic       line_wrap;
    logic [7:0] fetch_col;
    logic [7:0] fetch_line;
    logic [7:0] row;
    map_addr_t  map_addr;
    logic       nxt_hf;
    logic       nxt_prio;
    logic [3:0] nxt_pal;
    tile_row_t  nxt_data;
    tile_row_t  shifter;
    logic       cur_hf;
    logic       cur_prio;
    logic [3:0] cur_pal;
    logic [3:0] pixel;

    assign code_we = scr_cs & ~cpu_rnw & ~cpu_addr[11] & ~cpu_addr[10];
    assign attr_we = scr_cs & ~cpu_rnw & ~cpu_addr[11] &  cpu_addr[10];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scroll  <= '0;
            cpu_sel <= '0;
        end else begin
            if (scr_cs && !cpu_rnw && cpu_addr[11]) begin
                scroll <= cpu_dout;
            end
            cpu_sel <= cpu_addr[11:10];
        end
    end

    assign scr_rd = cpu_sel[1] ? scroll : (cpu_sel[0] ? attr_q : code_q);

    // Next tile; the last hblank tile fetches column 0 of the next line
    always_comb begin
        h_next     = hdump + hcount_t'(8);
        line_wrap  = h_next >= `VID_H_TOTAL;
        fetch_col  = line_wrap ? 8'd0 : h_next[7:0];
        fetch_line = vdump[7:0] + {7'd0, line_wrap};
        row        = (fetch_col < `VID_SCORE_COLS) ? fetch_line : fetch_line + scroll;
        map_addr   = {row[7:3], fetch_col[7:3]};
    end

    dual_port_ram #(.AW(10), .DW(8)) code_ram (
        .clk     (clk),
        .we      (code_we),
        .wr_addr (cpu_addr[9:0]),
        .wr_data (cpu_dout),
        .cpu_q   (code_q),
        .rd_addr (map_addr),
        .rd_q    (code)
    );

    dual_port_ram #(.AW(10), .DW(8)) attr_ram (
        .clk     (clk),
        .we      (attr_we),
        .wr_addr (cpu_addr[9:0]),
        .wr_data (cpu_dout),
        .cpu_q   (attr_q),
        .rd_addr (map_addr),
        .rd_q    (attr)
    );

    // Phase 0 issues the ROM address, phase 4 grabs the row, phase 7 hands it over
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (hdump[2:0] == 3'd0) begin
                scr_rom_addr <= {attr[5], code, row[2:0] ^ {3{attr[7]}}};    // vflip
                nxt_hf       <= attr[6];
                nxt_prio     <= attr[4];
                nxt_pal      <= attr[3:0];
            end
            if (hdump[2:0] == 3'd4) begin
                nxt_data <= scr_rom_data;
            end
            if (hdump[2:0] == 3'd7) begin
                shifter  <= nxt_data;
                cur_hf   <= nxt_hf;
                cur_prio <= nxt_prio;
                cur_pal  <= nxt_pal;
            end else begin
                shifter <= cur_hf ? shifter >> 4 : shifter << 4;
            end
        end
    end

    assign pixel = cur_hf ? shifter[3:0] : shifter[31:28];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scr_idx  <= '0;
            scr_prio <= 1'b0;
        end else if (pxl_cen) begin
            scr_idx  <= {cur_pal, pixel};
            scr_prio <= cur_prio;
        end
    end

endmodule

//--- hw/text_layer.sv
// Text layer: fixed 1bpp character overlay with glyph fetch and a text colour register
`timescale 1ns/1ps
`include "vid_consts.svh"

module text_layer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  vid_pkg::hcount_t        hdump,
    input  vid_pkg::vcount_t        vdump,
    input  logic                    txt_cs,
    input  logic                    cpu_rnw,
    input  vid_pkg::cpu_addr_t      cpu_addr,
    input  vid_pkg::cpu_data_t      cpu_dout,
    output vid_pkg::cpu_data_t      txt_rd,
    output vid_pkg::txt_rom_addr_t  txt_rom_addr,
    input  vid_pkg::glyph_row_t     txt_rom_data,
    output vid_pkg::pix_idx_t       txt_idx,
    output logic                    txt_opaque
);
    import vid_pkg::*;

    pix_idx_t   color;        // Written at 0xC01
    cpu_data_t  code;
    cpu_data_t  code_q;
    logic       cpu_sel;
    logic       code_we;
    hcount_t    h_next;
    logic       line_wrap;
    logic [7:0] fetch_col;
    logic [7:0] fetch_line;
    glyph_row_t nxt_glyph;
    glyph_row_t shifter;

    assign code_we = txt_cs & ~cpu_rnw & ~cpu_addr[10];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            color   <= '0;
            cpu_sel <= 1'b0;
        end else begin
            if (txt_cs && !cpu_rnw && cpu_addr[10]) begin
                color <= cpu_dout;
            end
            cpu_sel <= cpu_addr[10];
        end
    end

    assign txt_rd  = cpu_sel ? color : code_q;
    assign txt_idx = color;

    // One tile ahead, no scroll
    always_comb begin
        h_next     = hdump + hcount_t'(8);
        line_wrap  = h_next >= `VID_H_TOTAL;
        fetch_col  = line_wrap ? 8'd0 : h_next[7:0];
        fetch_line = vdump[7:0] + {7'd0, line_wrap};
    end

    dual_port_ram #(.AW(10), .DW(8)) code_ram (
        .clk     (clk),
        .we      (code_we),
        .wr_addr (cpu_addr[9:0]),
        .wr_data (cpu_dout),
        .cpu_q   (code_q),
        .rd_addr ({fetch_line[7:3], fetch_col[7:3]}),
        .rd_q    (code)
    );

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (hdump[2:0] == 3'd0) begin
                txt_rom_addr <= {code, fetch_line[2:0]};
            end
            if (hdump[2:0] == 3'd4) begin
                nxt_glyph <= txt_rom_data;
            end
            shifter <= (hdump[2:0] == 3'd7) ? nxt_glyph : shifter << 1;    // MSB first
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txt_opaque <= 1'b0;
        end else if (pxl_cen) begin
            txt_opaque <= shifter[7];
        end
    end

endmodule

//--- hw/vid_consts.svh
// Tile video constants: raster geometry, CPU address map and pixel pipeline depth
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

// Raster, in pixel steps and lines
`define VID_H_TOTAL     384
`define VID_H_ACTIVE    256
`define VID_V_TOTAL     264
`define VID_V_START     16
`define VID_V_END       239

`define VID_SCORE_COLS  32                     // Unscrolled columns on the left
`define VID_LAYER_LAT   1                      // Counter to layer output
`define VID_PIPE_LAT    (`VID_LAYER_LAT + 2)   // Plus mixer and palette

// CPU map
`define ADDR_SCR_CODE   12'h000
`define ADDR_SCR_ATTR   12'h400
`define ADDR_TXT_CODE   12'h800
`define ADDR_SCROLL     12'hC00
`define ADDR_TXT_COLOR  12'hC01
`define ADDR_PAL        12'hD00

`endif

//--- hw/vid_pkg.sv
// Tile video types: vector widths shared by the timing, layers, mixer and CPU decode
package vid_pkg;

    // CPU bus
    typedef logic [11:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // Raster counters
    typedef logic [8:0]  hcount_t;
    typedef logic [8:0]  vcount_t;

    typedef logic [9:0]  map_addr_t;       // {tile row, tile column}

    // Scroll tiles, {code[8], code[7:0], row}
    typedef logic [11:0] scr_rom_addr_t;
    typedef logic [31:0] tile_row_t;       // Leftmost pixel in [31:28]

    // Text glyphs, {code, row}
    typedef logic [10:0] txt_rom_addr_t;
    typedef logic [7:0]  glyph_row_t;      // Leftmost pixel in MSB

    typedef logic [7:0]  pix_idx_t;        // {palette, pixel}
    typedef logic [7:0]  rgb_t;            // RGB332

endpackage

//--- hw/video_timing.sv
// Video timing: pixel enable, raster counters, blanking and blanking aligned to rgb
`timescale 1ns/1ps
`include "vid_consts.svh"

module video_timing (
    input  logic               clk,
    input  logic               rst,
    output logic               pxl_cen,
    output vid_pkg::hcount_t   hdump,
    output vid_pkg::vcount_t   vdump,
    output logic               lhbl,
    output logic               lvbl,
    output logic               de_out,
    output logic               lhbl_out,
    output logic               lvbl_out
);
    import vid_pkg::*;

    logic [`VID_PIPE_LAT-1:0] lhbl_sr;
    logic [`VID_PIPE_LAT-1:0] lvbl_sr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl_cen <= 1'b0;
            hdump   <= '0;
            vdump   <= '0;
        end else begin
            pxl_cen <= ~pxl_cen;    // Half of clk
            if (pxl_cen) begin
                if (hdump == hcount_t'(`VID_H_TOTAL - 1)) begin
                    hdump <= '0;
                    vdump <= (vdump == vcount_t'(`VID_V_TOTAL - 1)) ? '0 : vdump + 1'b1;
                end else begin
                    hdump <= hdump + 1'b1;
                end
            end
        end
    end

    assign lhbl = hdump < `VID_H_ACTIVE;
    assign lvbl = vdump >= `VID_V_START && vdump <= `VID_V_END;

    // Delay by the layer, mixer and palette stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_sr <= '0;
            lvbl_sr <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[`VID_PIPE_LAT-2:0], lhbl};
            lvbl_sr <= {lvbl_sr[`VID_PIPE_LAT-2:0], lvbl};
        end
    end

    assign lhbl_out = lhbl_sr[`VID_PIPE_LAT-1];
    assign lvbl_out = lvbl_sr[`VID_PIPE_LAT-1];
    assign de_out   = lhbl_out & lvbl_out;

endmodule

//--- hw/video_top.sv
// Tile video top: timing, CPU decode, scroll and text layers and the mixer
`timescale 1ns/1ps

module video_top (
    input  logic                    clk,
    input  logic                    rst,
    // CPU bus
    input  logic                    cpu_cs,
    input  logic                    cpu_rnw,
    input  vid_pkg::cpu_addr_t      cpu_addr,
    input  vid_pkg::cpu_data_t      cpu_dout,
    output vid_pkg::cpu_data_t      cpu_din,
    // Tile and glyph ROMs
    output vid_pkg::scr_rom_addr_t  scr_rom_addr,
    input  vid_pkg::tile_row_t      scr_rom_data,
    output vid_pkg::txt_rom_addr_t  txt_rom_addr,
    input  vid_pkg::glyph_row_t     txt_rom_data,
    // Video out
    output vid_pkg::rgb_t           rgb,
    output logic                    de_out,
    output logic                    lhbl_out,
    output logic                    lvbl_out
);
    import vid_pkg::*;

    logic      pxl_cen;
    hcount_t   hdump;
    vcount_t   vdump;
    logic      scr_cs;
    logic      txt_cs;
    logic      pal_cs;
    cpu_data_t scr_rd;
    cpu_data_t txt_rd;
    cpu_data_t pal_rd;
    pix_idx_t  scr_idx;
    logic      scr_prio;
    pix_idx_t  txt_idx;
    logic      txt_opaque;

    video_timing timing_i (
        .clk, .rst, .pxl_cen, .hdump, .vdump,
        .lhbl (), .lvbl (),    // Undelayed blanking not needed here
        .de_out, .lhbl_out, .lvbl_out
    );

    cpu_decode decode_i (
        .clk, .rst, .cpu_cs, .cpu_rnw, .cpu_addr,
        .scr_cs, .txt_cs, .pal_cs, .scr_rd, .txt_rd, .pal_rd, .cpu_din
    );

    scroll_layer scroll_i (
        .clk, .rst, .pxl_cen, .hdump, .vdump, .scr_cs, .cpu_rnw, .cpu_addr, .cpu_dout,
        .scr_rd, .scr_rom_addr, .scr_rom_data, .scr_idx, .scr_prio
    );

    text_layer text_i (
        .clk, .rst, .pxl_cen, .hdump, .vdump, .txt_cs, .cpu_rnw, .cpu_addr, .cpu_dout,
        .txt_rd, .txt_rom_addr, .txt_rom_data, .txt_idx, .txt_opaque
    );

    layer_mixer mixer_i (
        .clk, .rst, .pxl_cen, .scr_idx, .scr_prio, .txt_idx, .txt_opaque,
        .pal_cs, .cpu_rnw, .cpu_addr, .cpu_dout, .pal_rd, .rgb
    );

endmodule

//--- sim.f
+incdir+hw
hw/vid_pkg.sv
hw/dual_port_ram.sv
hw/cpu_decode.sv
hw/video_timing.sv
hw/scroll_layer.sv
hw/text_layer.sv
hw/layer_mixer.sv
hw/video_top.sv
verification/video_tb.sv

//--- verification/video_tb.sv
// Tile video testbench checking CPU read back and every visible rgb value against a model
`timescale 1ns/1ps
`include "vid_consts.svh"

module video_tb;
    import vid_pkg::*;

    localparam int WAIT_LIMIT = 250000;    // More clk cycles than one whole frame
    localparam int STEP_LIMIT = 100000;    // Pixel steps in one visible field plus margin

    logic          clk;
    logic          rst;
    logic          cpu_cs;
    logic          cpu_rnw;
    cpu_addr_t     cpu_addr;
    cpu_data_t     cpu_dout;
    cpu_data_t     cpu_din;
    scr_rom_addr_t scr_rom_addr;
    tile_row_t     scr_rom_data;
    txt_rom_addr_t txt_rom_addr;
    glyph_row_t    txt_rom_data;
    rgb_t          rgb;
    logic          de_out;
    logic          lhbl_out;
    logic          lvbl_out;

    // ROM images and the model copy of every CPU visible byte
    tile_row_t   scr_rom   [0:4095];
    glyph_row_t  glyph_rom [0:2047];
    cpu_data_t   code_m    [0:1023];
    cpu_data_t   attr_m    [0:1023];
    cpu_data_t   txtc_m    [0:1023];
    rgb_t        pal_m     [0:255];
    cpu_data_t   scroll_m;
    cpu_data_t   color_m;
    logic [15:0] lfsr;

    video_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .cpu_cs       (cpu_cs),
        .cpu_rnw      (cpu_rnw),
        .cpu_addr     (cpu_addr),
        .cpu_dout     (cpu_dout),
        .cpu_din      (cpu_din),
        .scr_rom_addr (scr_rom_addr),
        .scr_rom_data (scr_rom_data),
        .txt_rom_addr (txt_rom_addr),
        .txt_rom_data (txt_rom_data),
        .rgb          (rgb),
        .de_out       (de_out),
        .lhbl_out     (lhbl_out),
        .lvbl_out     (lvbl_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // External ROMs answer half a clk after the address edge
    always @(negedge clk) begin
        scr_rom_data <= scr_rom[scr_rom_addr];
        txt_rom_data <= glyph_rom[txt_rom_addr];
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};    // One step per bit
        end
        return r;
    endfunction

    function automatic cpu_data_t model_byte(input cpu_addr_t a);
        if (a < `ADDR_SCR_ATTR) return code_m[a[9:0]];
        if (a < `ADDR_TXT_CODE) return attr_m[a[9:0]];
        if (a < `ADDR_SCROLL) return txtc_m[a[9:0]];
        if (a == `ADDR_SCROLL) return scroll_m;
        if (a == `ADDR_TXT_COLOR) return color_m;
        if (a >= `ADDR_PAL && a < `ADDR_PAL + 256) return pal_m[a[7:0]];
        return 8'h00;    // Unmapped
    endfunction

    // Expected colour of one visible pixel
    function automatic rgb_t model_rgb(input logic [7:0] line, input logic [7:0] col);
        logic [7:0] row;
        logic [9:0] map;
        logic [7:0] attr;
        logic [2:0] trow;
        tile_row_t  tile;
        int         nib;
        logic [3:0] pix;
        glyph_row_t glyph;
        logic       opaque;
        pix_idx_t   idx;
        row    = (col < `VID_SCORE_COLS) ? line : line + scroll_m;    // Score area fixed
        map    = {row[7:3], col[7:3]};
        attr   = attr_m[map];
        trow   = row[2:0] ^ {3{attr[7]}};
        tile   = scr_rom[{attr[5], code_m[map], trow}];
        nib    = attr[6] ? 7 - col[2:0] : col[2:0];                   // hflip
        pix    = tile[(7 - nib) * 4 +: 4];
        glyph  = glyph_rom[{txtc_m[{line[7:3], col[7:3]}], line[2:0]}];
        opaque = glyph[7 - col[2:0]];
        idx    = (opaque && !(attr[4] && pix != 4'd0)) ? color_m : {attr[3:0], pix};
        return pal_m[idx];
    endfunction

    task automatic fail_stop();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            fail_stop();
        end
    endtask

    // CPU write commits on the next rising edge and updates the model
    task automatic store(input cpu_addr_t a, input cpu_data_t d);
        @(negedge clk);
        cpu_cs   = 1'b1;
        cpu_rnw  = 1'b0;
        cpu_addr = a;
        cpu_dout = d;
        if (a < `ADDR_SCR_ATTR) code_m[a[9:0]] = d;
        else if (a < `ADDR_TXT_CODE) attr_m[a[9:0]] = d;
        else if (a < `ADDR_SCROLL) txtc_m[a[9:0]] = d;
        else if (a == `ADDR_SCROLL) scroll_m = d;
        else if (a == `ADDR_TXT_COLOR) color_m = d;
        else if (a >= `ADDR_PAL && a < `ADDR_PAL + 256) pal_m[a[7:0]] = d;
    endtask

    task automatic read_check(input cpu_addr_t a);
        @(negedge clk);
        cpu_cs   = 1'b1;    // Strobe
        cpu_rnw  = 1'b1;
        cpu_addr = a;
        @(negedge clk);
        cpu_cs = 1'b0;
        check_value($sformatf("cpu_din at %03h", a), cpu_din, model_byte(a));    // One clk later
    endtask

    task automatic bus_idle();
        @(negedge clk);
        cpu_cs  = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    task automatic wait_lvbl(input logic level);
        int cnt;
        cnt = 0;
        while (lvbl_out !== level) begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                $display("Timeout: lvbl_out never reached %0d", level);
                fail_stop();
            end
        end
    endtask

    // Outputs move on enabled edges and are sampled just after pxl_cen drops
    task automatic next_pixel();
        @(negedge clk);
        if (pxl_cen_seen()) @(negedge clk);
    endtask

    function automatic logic pxl_cen_seen();
        return dut_i.pxl_cen;
    endfunction

    // Checks one full field from its first line
    task automatic check_frame();
        logic [16:0] n;
        int          col_cnt;
        int          lines;
        int          steps;
        int          hpos;
        wait_lvbl(1'b1);
        wait_lvbl(1'b0);
        wait_lvbl(1'b1);
        n       = '0;
        col_cnt = 0;
        lines   = 0;
        steps   = 0;
        hpos    = 0;    // lvbl_out rises with the first pixel of a line
        while (lvbl_out) begin
            check_value("lhbl_out", lhbl_out, hpos < `VID_H_ACTIVE);
            if (de_out) begin
                check_value($sformatf("rgb line %0d col %0d", n[15:8] + 16, n[7:0]), rgb,
                            model_rgb(n[15:8] + 8'd16, n[7:0]));
                n++;
                col_cnt++;
            end else if (col_cnt != 0) begin
                check_value("de_out pixels in line", col_cnt, `VID_H_ACTIVE);
                lines++;
                col_cnt = 0;
            end
            next_pixel();
            hpos = (hpos + 1) % `VID_H_TOTAL;
            steps++;
            if (steps > STEP_LIMIT) begin
                $display("Timeout: lvbl_out stayed high for too long");
                fail_stop();
            end
        end
        check_value("visible lines", lines, `VID_V_END - `VID_V_START + 1);
        check_value("de_out pixels in frame", n, 224 * 256);
    endtask

    initial begin
        logic [12:0] a;
        cpu_data_t   val;
        rst          = 1'b1;
        cpu_cs       = 1'b0;
        cpu_rnw      = 1'b1;
        cpu_addr     = '0;
        cpu_dout     = '0;
        scr_rom_data = '0;
        txt_rom_data = '0;
        lfsr         = 16'd89;
        for (int i = 0; i < 4096; i++) scr_rom[i] = rand_bits(32);
        for (int i = 0; i < 2048; i++) glyph_rom[i] = rand_bits(8);
        for (int i = 0; i < 8; i++) glyph_rom[i] = 8'h00;    // Code 0 is blank
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Fill every region, then read the whole map back
        for (a = 0; a < `ADDR_SCROLL; a++) store(a[11:0], rand_bits(8));
        store(`ADDR_SCROLL, rand_bits(8));
        store(`ADDR_TXT_COLOR, rand_bits(8));
        for (a = `ADDR_PAL; a < `ADDR_PAL + 256; a++) store(a[11:0], rand_bits(8));
        for (a = 0; a < 13'h1000; a++) read_check(a[11:0]);    // Holes give 0

        // Plain tiles, blank text, no scroll
        for (a = `ADDR_SCR_ATTR; a < `ADDR_TXT_CODE; a++) store(a[11:0], 8'h00);
        for (a = `ADDR_TXT_CODE; a < `ADDR_SCROLL; a++) store(a[11:0], 8'h00);
        store(`ADDR_SCROLL, 8'h00);
        bus_idle();
        check_frame();

        val = rand_bits(8);
        if (val == 8'h00) val = 8'h01;
        store(`ADDR_SCROLL, val);
        bus_idle();
        check_frame();

        // Flips, code bit 8, palettes and priority
        for (a = `ADDR_SCR_ATTR; a < `ADDR_TXT_CODE; a++) store(a[11:0], rand_bits(8));
        bus_idle();
        check_frame();

        // Text over scroll
        for (a = `ADDR_TXT_CODE; a < `ADDR_SCROLL; a++) store(a[11:0], rand_bits(8));
        store(`ADDR_TXT_COLOR, rand_bits(8));
        bus_idle();
        check_frame();

        $display("*** PASSED ***");
        $finish;
    end

endmodule
